//--- bench/tb_cnn_quad.sv
`include "quad_config.svh"
`default_nettype none

module tb_cnn_quad;

    timeunit 1ns;
    timeprecision 100ps;

    // Two jobs, the second one at full row depth with ReLU
    localparam int J1_COLS    = 12;
    localparam int J1_ROWS    = 3;
    localparam int J1_KERNELS = 3;
    localparam int J2_COLS    = 64;
    localparam int J2_ROWS    = 2;
    localparam int J2_KERNELS = 4;

    logic         clk_core;
    logic         rst;
    logic         job_start;
    logic         job_accept;
    logic [127:0] job_parameters;
    logic         job_fetch_request;
    logic         job_fetch_ack;
    logic         job_complete;
    logic         job_complete_ack;
    logic         pixel_valid;
    logic         pixel_ready;
    logic [127:0] pixel_data;
    logic         weight_valid;
    logic         weight_ready;
    logic [127:0] weight_data;
    logic         result_valid;
    logic [15:0]  result_data;

    // Reference model storage
    shortint      wgt [`QUAD_MAX_KERNELS][`QUAD_LANES];
    shortint      row_pix [`QUAD_MAX_COLS][`QUAD_LANES];
    logic [15:0]  exp_mem [1024];
    logic [9:0]   exp_wr = '0;
    logic [9:0]   exp_rd = '0;
    logic [15:0]  exp_head;

    int           cur_cols;
    int           cur_rows;
    int           cur_kernels;
    bit           cur_relu;
    int           req_count = 0;
    int           beat_count = 0;
    logic         req_q = 1'b0;
    logic         in_reset_q = 1'b0;
    logic [31:0]  rng_state = 32'hc0c45c1a;

    cnn_quad_top u_cnn_quad_top (
        .clk_core          (clk_core),
        .rst               (rst),
        .job_start         (job_start),
        .job_accept        (job_accept),
        .job_parameters    (job_parameters),
        .job_fetch_request (job_fetch_request),
        .job_fetch_ack     (job_fetch_ack),
        .job_complete      (job_complete),
        .job_complete_ack  (job_complete_ack),
        .pixel_valid       (pixel_valid),
        .pixel_ready       (pixel_ready),
        .pixel_data        (pixel_data),
        .weight_valid      (weight_valid),
        .weight_ready      (weight_ready),
        .weight_data       (weight_data),
        .result_valid      (result_valid),
        .result_data       (result_data)
    );

    always #4 clk_core = ~clk_core;

    assign exp_head = exp_mem[exp_rd];

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Low 16 bits of the signed dot product of one column and one kernel
    function automatic logic [15:0] dot_low16(input int col, input int kern, input bit relu);
        longint acc;
        longint p;
        acc = 0;
        for (int l = 0; l < `QUAD_LANES; l++) begin
            p = longint'(row_pix[col][l]);
            if (relu && p < 0) begin
                p = 0;
            end
            acc = acc + p * longint'(wgt[kern][l]);
        end
        return acc[15:0];
    endfunction

    function automatic int job_cycles(input int cols, input int rows, input int kernels);
        return rows * (kernels * cols + cols + 20);
    endfunction

    task end_in_failure();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task show_mismatch(input string name, input logic [15:0] got, input logic [15:0] want);
        $display("ERROR %s got 0x%04h expected 0x%04h", name, got, want);
        end_in_failure();
    endtask

    task show_failure(input string what);
        $display("Check failed: %s", what);
        end_in_failure();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Monitor counters
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk_core) begin
        in_reset_q <= rst;
        req_q      <= job_fetch_request;
        if (weight_ready) begin
            req_count <= 0;
        end else if (job_fetch_request && !req_q) begin
            req_count <= req_count + 1;
        end
        if (job_fetch_ack) begin
            beat_count <= 0;
        end else if (pixel_valid && pixel_ready) begin
            beat_count <= beat_count + 1;
        end
        if (result_valid) begin
            exp_rd <= exp_rd + 10'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk_core) in_reset_q |-> !job_accept && !job_fetch_request
            && !job_complete && !result_valid && !pixel_ready && weight_ready)
        else show_failure("outputs are not at their reset values during reset");

    assert property (@(posedge clk_core) disable iff (rst)
            job_start && weight_ready |=> job_accept)
        else show_failure("job_accept did not follow job_start in idle");

    assert property (@(posedge clk_core) disable iff (rst)
            job_accept |-> $past(job_start) && $past(weight_ready))
        else show_failure("job_accept came without job_start in idle");

    assert property (@(posedge clk_core) disable iff (rst) job_accept |=> !job_accept)
        else show_failure("job_accept lasted more than one cycle");

    assert property (@(posedge clk_core) disable iff (rst)
            job_accept || job_fetch_request || pixel_ready || result_valid |-> !weight_ready)
        else show_failure("weight_ready is high while a job runs");

    assert property (@(posedge clk_core) disable iff (rst) result_valid |-> exp_rd != exp_wr)
        else show_failure("a result arrived while none was expected");

    assert property (@(posedge clk_core) disable iff (rst)
            result_valid |-> result_data == exp_head)
        else show_mismatch("result_data", $sampled(result_data), $sampled(exp_head));

    // The row must close after exactly its column count of beats
    assert property (@(posedge clk_core) disable iff (rst)
            pixel_ready |-> beat_count < cur_cols)
        else show_failure("pixel_ready stayed high after the whole row was fetched");

    assert property (@(posedge clk_core) disable iff (rst)
            result_valid |-> beat_count == cur_cols)
        else show_failure("a result came before the whole row was fetched");

    assert property (@(posedge clk_core) disable iff (rst)
            $rose(job_complete) |-> req_count == cur_rows)
        else show_mismatch("job_fetch_request rises", 16'($sampled(req_count)), 16'(cur_rows));

    assert property (@(posedge clk_core) disable iff (rst)
            $rose(job_complete) |-> exp_rd == exp_wr)
        else show_failure("job_complete rose with results still outstanding");

    assert property (@(posedge clk_core) disable iff (rst)
            job_complete && job_complete_ack |=> !job_complete && weight_ready)
        else show_failure("job_complete did not fall after job_complete_ack");

    //////////////////////////////////////////////////////////////////////
    // Host model
    //////////////////////////////////////////////////////////////////////

    task load_weights(input int kernels);
        logic [31:0]  rnd;
        logic [127:0] beat;
        for (int k = 0; k < kernels; k++) begin
            for (int l = 0; l < `QUAD_LANES; l++) begin
                rnd = next_random();
                wgt[k][l] = rnd[15:0];
                beat[16*l +: 16] = rnd[15:0];
            end
            @(posedge clk_core);
            weight_valid <= 1'b1;
            weight_data  <= beat;
        end
        @(posedge clk_core);
        weight_valid <= 1'b0;
    endtask

    // Column fastest, then kernel
    task queue_row_results();
        for (int k = 0; k < cur_kernels; k++) begin
            for (int c = 0; c < cur_cols; c++) begin
                exp_mem[exp_wr] = dot_low16(c, k, cur_relu);
                exp_wr = exp_wr + 10'd1;
            end
        end
    endtask

    task fetch_row();
        int           beats;
        bit           pending;
        logic [31:0]  rnd;
        logic [127:0] beat;
        beats   = 0;
        pending = 1'b0;
        @(negedge clk_core);
        while (!job_fetch_request) begin
            @(negedge clk_core);
        end
        @(posedge clk_core);
        job_fetch_ack <= 1'b1;
        @(posedge clk_core);
        job_fetch_ack <= 1'b0;
        while (beats < cur_cols) begin
            if (!pending) begin
                for (int l = 0; l < `QUAD_LANES; l++) begin
                    rnd = next_random();
                    row_pix[beats][l] = rnd[15:0];
                    beat[16*l +: 16] = rnd[15:0];
                end
                pending = 1'b1;
            end
            rnd = next_random();
            // Source idles about one cycle in four
            if (rnd[1:0] == 2'b00) begin
                pixel_valid <= 1'b0;
            end else begin
                pixel_valid <= 1'b1;
                pixel_data  <= beat;
            end
            @(negedge clk_core);
            if (pixel_valid && pixel_ready) begin
                beats++;
                pending = 1'b0;
            end
            @(posedge clk_core);
        end
        pixel_valid <= 1'b0;
        queue_row_results();
    endtask

    task run_job(input int cols, input int rows, input int kernels, input bit relu);
        logic [127:0] jp;
        cur_cols    = cols;
        cur_rows    = rows;
        cur_kernels = kernels;
        cur_relu    = relu;
        load_weights(kernels);
        jp = '0;
        jp[`QUAD_JP_COLS_HI:`QUAD_JP_COLS_LO] = 8'(cols);
        jp[`QUAD_JP_ROWS_HI:`QUAD_JP_ROWS_LO] = 8'(rows);
        jp[`QUAD_JP_KERN_HI:`QUAD_JP_KERN_LO] = 4'(kernels);
        jp[`QUAD_JP_RELU_BIT] = relu;
        @(posedge clk_core);
        job_parameters <= jp;
        job_start      <= 1'b1;
        @(posedge clk_core);
        job_start <= 1'b0;
        for (int r = 0; r < rows; r++) begin
            fetch_row();
        end
        @(negedge clk_core);
        while (!job_complete) begin
            @(negedge clk_core);
        end
        @(posedge clk_core);
        job_complete_ack <= 1'b1;
        @(posedge clk_core);
        job_complete_ack <= 1'b0;
    endtask

    initial begin
        clk_core         = 1'b0;
        rst              = 1'b1;
        job_start        = 1'b0;
        job_parameters   = '0;
        job_fetch_ack    = 1'b0;
        job_complete_ack = 1'b0;
        pixel_valid      = 1'b0;
        pixel_data       = '0;
        weight_valid     = 1'b0;
        weight_data      = '0;
        cur_cols         = 0;
        cur_rows         = 0;
        cur_kernels      = 0;
        cur_relu         = 1'b0;
        repeat (16) @(posedge clk_core);
        rst <= 1'b0;
        repeat (2) @(posedge clk_core);
        run_job(J1_COLS, J1_ROWS, J1_KERNELS, 1'b0);
        run_job(J2_COLS, J2_ROWS, J2_KERNELS, 1'b1);
        repeat (4) @(posedge clk_core);
        $display("TESTS PASSED");
        $finish;
    end

    // Watchdog sized from the job geometry
    initial begin
        int limit;
        limit = 4 * (job_cycles(J1_COLS, J1_ROWS, J1_KERNELS)
                   + job_cycles(J2_COLS, J2_ROWS, J2_KERNELS));
        repeat (limit) @(posedge clk_core);
        $display("Timeout: the jobs did not finish within %0d cycles", limit);
        end_in_failure();
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+hw
hw/quad_data_pkg.sv
hw/quad_job_pkg.sv
hw/quad_job_ctrl.sv
hw/quad_prefetch_buffer.sv
hw/quad_weight_table.sv
hw/quad_mac_pipe.sv
hw/cnn_quad_top.sv
bench/tb_cnn_quad.sv

//--- hw/cnn_quad_top.sv
`include "quad_config.svh"
`default_nettype none

module cnn_quad_top
    import quad_data_pkg::*;
    import quad_job_pkg::*;
(
    input  logic      clk_core,
    input  logic      rst,
    input  logic      job_start,
    output logic      job_accept,
    input  job_word_t job_parameters,
    output logic      job_fetch_request,
    input  logic      job_fetch_ack,
    output logic      job_complete,
    input  logic      job_complete_ack,
    input  logic      pixel_valid,
    output logic      pixel_ready,
    input  lane_vec_t pixel_data,
    input  logic      weight_valid,
    output logic      weight_ready,
    input  lane_vec_t weight_data,
    output logic      result_valid,
    output pixel_t    result_data
);

    logic      pfb_wr_en;
    col_t      pfb_wr_col;
    logic      rd_valid;
    logic      rd_valid_q;
    col_t      rd_col;
    kernel_t   rd_kernel;
    logic      relu_en;
    lane_vec_t pfb_rd_data;
    lane_vec_t wt_rd_data;

    quad_job_ctrl u_quad_job_ctrl (
        .clk_core          (clk_core),
        .rst               (rst),
        .job_start         (job_start),
        .job_accept        (job_accept),
        .job_parameters    (job_parameters),
        .job_fetch_request (job_fetch_request),
        .job_fetch_ack     (job_fetch_ack),
        .job_complete      (job_complete),
        .job_complete_ack  (job_complete_ack),
        .pixel_valid       (pixel_valid),
        .pixel_ready       (pixel_ready),
        .weight_ready      (weight_ready),
        .pfb_wr_en         (pfb_wr_en),
        .pfb_wr_col        (pfb_wr_col),
        .rd_valid          (rd_valid),
        .rd_col            (rd_col),
        .rd_kernel         (rd_kernel),
        .relu_en           (relu_en)
    );

    quad_prefetch_buffer u_quad_prefetch_buffer (
        .clk_core   (clk_core),
        .wr_en      (pfb_wr_en),
        .wr_col     (pfb_wr_col),
        .pixel_data (pixel_data),
        .rd_col     (rd_col),
        .rd_data    (pfb_rd_data)
    );

    quad_weight_table u_quad_weight_table (
        .clk_core         (clk_core),
        .rst              (rst),
        .weight_valid     (weight_valid),
        .weight_ready     (weight_ready),
        .job_complete_ack (job_complete_ack),
        .weight_data      (weight_data),
        .rd_kernel        (rd_kernel),
        .rd_weights       (wt_rd_data)
    );

    // Read strobe lined up with the registered memory outputs
    always_ff @(posedge clk_core) begin
        if (rst) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_valid;
        end
    end

    quad_mac_pipe u_quad_mac_pipe (
        .clk_core     (clk_core),
        .rst          (rst),
        .in_valid     (rd_valid_q),
        .relu_en      (relu_en),
        .pixels       (pfb_rd_data),
        .weights      (wt_rd_data),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

endmodule

`default_nettype wire

//--- hw/quad_config.svh
`ifndef QUAD_CONFIG_SVH
`define QUAD_CONFIG_SVH

// Datapath sizes
`define QUAD_LANES          8
`define QUAD_PIXEL_W        16
`define QUAD_BUS_W          128
`define QUAD_ACC_W          40

// Storage depths and index widths
`define QUAD_MAX_COLS       64
`define QUAD_MAX_KERNELS    16
`define QUAD_COL_W          6
`define QUAD_KERNEL_W       4
`define QUAD_ROW_W          8

// Read strobe to result, memory read included
`define QUAD_PIPE_DEPTH     3

// Field positions inside job_parameters
`define QUAD_JP_COLS_HI     7
`define QUAD_JP_COLS_LO     0
`define QUAD_JP_ROWS_HI     15
`define QUAD_JP_ROWS_LO     8
`define QUAD_JP_KERN_HI     19
`define QUAD_JP_KERN_LO     16
`define QUAD_JP_RELU_BIT    20

`endif

//--- hw/quad_data_pkg.sv
`include "quad_config.svh"
`default_nettype none

package quad_data_pkg;

    // Pixels and weights share one signed format
    typedef logic signed [`QUAD_PIXEL_W-1:0] pixel_t;

    // Lane 0 sits in the low bits of the bus
    typedef pixel_t [`QUAD_LANES-1:0] lane_vec_t;

    // Full product of one pixel and one weight
    typedef logic signed [2*`QUAD_PIXEL_W-1:0] prod_t;

    typedef logic signed [`QUAD_ACC_W-1:0] acc_t;

    // Row buffer and weight table addresses
    typedef logic [`QUAD_COL_W-1:0]    col_t;
    typedef logic [`QUAD_KERNEL_W-1:0] kernel_t;

endpackage

`default_nettype wire

//--- hw/quad_job_ctrl.sv
`include "quad_config.svh"
`default_nettype none

module quad_job_ctrl
    import quad_data_pkg::*;
    import quad_job_pkg::*;
(
    input  logic      clk_core,
    input  logic      rst,
    input  logic      job_start,
    output logic      job_accept,
    input  job_word_t job_parameters,
    output logic      job_fetch_request,
    input  logic      job_fetch_ack,
    output logic      job_complete,
    input  logic      job_complete_ack,
    input  logic      pixel_valid,
    output logic      pixel_ready,
    output logic      weight_ready,
    output logic      pfb_wr_en,
    output col_t      pfb_wr_col,
    output logic      rd_valid,
    output col_t      rd_col,
    output kernel_t   rd_kernel,
    output logic      relu_en
);

    localparam int DRAIN_W = $clog2(`QUAD_PIPE_DEPTH);
    localparam int NCOL_W  = `QUAD_JP_COLS_HI - `QUAD_JP_COLS_LO + 1;
    localparam int KCNT_W  = `QUAD_KERNEL_W + 1;

    quad_state_e            state;
    job_params_t            params;
    job_params_t            params_dec;
    col_t                   col_cnt;
    kernel_t                kern_cnt;
    logic [`QUAD_ROW_W-1:0] row_cnt;
    logic [DRAIN_W-1:0]     drain_cnt;
    logic                   col_last;
    logic                   kern_last;
    logic                   row_last;
    logic                   drain_done;

    //////////////////////////////////////////////////////////////////////
    // Job word decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        params_dec.num_cols = job_parameters[`QUAD_JP_COLS_HI:`QUAD_JP_COLS_LO];
        params_dec.num_rows = job_parameters[`QUAD_JP_ROWS_HI:`QUAD_JP_ROWS_LO];
        // Zero in the kernel field selects all 16 kernels
        params_dec.num_kernels = {job_parameters[`QUAD_JP_KERN_HI:`QUAD_JP_KERN_LO] == '0,
                                  job_parameters[`QUAD_JP_KERN_HI:`QUAD_JP_KERN_LO]};
        params_dec.relu_en = job_parameters[`QUAD_JP_RELU_BIT];
    end

    always_ff @(posedge clk_core) begin
        if (state == ST_IDLE && job_start) begin
            params <= params_dec;
        end
    end

    assign col_last   = (NCOL_W'(col_cnt) == params.num_cols - NCOL_W'(1));
    assign kern_last  = (KCNT_W'(kern_cnt) == params.num_kernels - KCNT_W'(1));
    assign row_last   = (row_cnt == params.num_rows - `QUAD_ROW_W'(1));
    assign drain_done = (drain_cnt == DRAIN_W'(`QUAD_PIPE_DEPTH - 1));

    //////////////////////////////////////////////////////////////////////
    // Outputs decoded from the state
    //////////////////////////////////////////////////////////////////////

    assign job_fetch_request = (state == ST_FETCH_REQ);
    assign job_complete      = (state == ST_SEND_COMPLETE);
    assign weight_ready      = (state == ST_IDLE);
    assign pixel_ready       = (state == ST_FETCH);
    assign rd_valid          = (state == ST_COMPUTE);
    assign pfb_wr_en         = pixel_valid && pixel_ready;

    // Fetch and compute never overlap, so one column counter serves both
    assign pfb_wr_col = col_cnt;
    assign rd_col     = col_cnt;
    assign rd_kernel  = kern_cnt;
    assign relu_en    = params.relu_en;

    //////////////////////////////////////////////////////////////////////
    // Job FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_core) begin
        if (rst) begin
            state      <= ST_IDLE;
            job_accept <= 1'b0;
            col_cnt    <= '0;
            kern_cnt   <= '0;
            row_cnt    <= '0;
            drain_cnt  <= '0;
        end else begin
            job_accept <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        row_cnt    <= '0;
                        state      <= ST_FETCH_REQ;
                    end
                end
                ST_FETCH_REQ: begin
                    if (job_fetch_ack) begin
                        col_cnt <= '0;
                        state   <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    // Only accepted beats advance the row
                    if (pfb_wr_en) begin
                        if (col_last) begin
                            col_cnt  <= '0;
                            kern_cnt <= '0;
                            state    <= ST_COMPUTE;
                        end else begin
                            col_cnt <= col_cnt + col_t'(1);
                        end
                    end
                end
                ST_COMPUTE: begin
                    // Column fastest, then kernel
                    if (col_last) begin
                        col_cnt <= '0;
                        if (kern_last) begin
                            drain_cnt <= '0;
                            state     <= ST_DRAIN;
                        end else begin
                            kern_cnt <= kern_cnt + kernel_t'(1);
                        end
                    end else begin
                        col_cnt <= col_cnt + col_t'(1);
                    end
                end
                ST_DRAIN: begin
                    // Let the last reads of the row leave the pipe
                    if (drain_done) begin
                        row_cnt <= row_cnt + `QUAD_ROW_W'(1);
                        if (row_last) begin
                            state <= ST_SEND_COMPLETE;
                        end else begin
                            state <= ST_FETCH_REQ;
                        end
                    end else begin
                        drain_cnt <= drain_cnt + DRAIN_W'(1);
                    end
                end
                ST_SEND_COMPLETE: begin
                    if (job_complete_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/quad_job_pkg.sv
`include "quad_config.svh"
`default_nettype none

package quad_job_pkg;

    // Raw job word as the host presents it
    typedef logic [`QUAD_BUS_W-1:0] job_word_t;

    typedef enum logic [2:0] {
        ST_IDLE          = 3'd0,
        ST_FETCH_REQ     = 3'd1,
        ST_FETCH         = 3'd2,
        ST_COMPUTE       = 3'd3,
        ST_DRAIN         = 3'd4,
        ST_SEND_COMPLETE = 3'd5
    } quad_state_e;

    // Decoded job geometry, held for the whole job
    typedef struct packed {
        logic [`QUAD_JP_COLS_HI:`QUAD_JP_COLS_LO] num_cols;
        logic [`QUAD_ROW_W-1:0]                   num_rows;
        logic [`QUAD_KERNEL_W:0]                  num_kernels;
        logic                                     relu_en;
    } job_params_t;

endpackage

`default_nettype wire

//--- hw/quad_mac_pipe.sv
`include "quad_config.svh"
`default_nettype none

module quad_mac_pipe
    import quad_data_pkg::*;
(
    input  logic      clk_core,
    input  logic      rst,
    input  logic      in_valid,
    input  logic      relu_en,
    input  lane_vec_t pixels,
    input  lane_vec_t weights,
    output logic      result_valid,
    output pixel_t    result_data
);

    lane_vec_t act;
    prod_t     prod_q [`QUAD_LANES];
    acc_t      tree_sum;
    acc_t      sum_q;
    logic      valid_q1;
    logic      valid_q2;

    //////////////////////////////////////////////////////////////////////
    // ReLU and products
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `QUAD_LANES; i++) begin
            if (relu_en && pixels[i][`QUAD_PIXEL_W-1]) begin
                act[i] = '0;
            end else begin
                act[i] = pixels[i];
            end
        end
    end

    always_ff @(posedge clk_core) begin
        for (int i = 0; i < `QUAD_LANES; i++) begin
            prod_q[i] <= $signed(act[i]) * $signed(weights[i]);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sum of the lane products
    //////////////////////////////////////////////////////////////////////

    // Products are sign-extended before the add
    always_comb begin
        tree_sum = '0;
        for (int i = 0; i < `QUAD_LANES; i++) begin
            tree_sum = tree_sum + acc_t'(prod_q[i]);
        end
    end

    always_ff @(posedge clk_core) begin
        sum_q <= tree_sum;
    end

    // Valid runs beside the data, two items in flight at most
    always_ff @(posedge clk_core) begin
        if (rst) begin
            valid_q1 <= 1'b0;
            valid_q2 <= 1'b0;
        end else begin
            valid_q1 <= in_valid;
            valid_q2 <= valid_q1;
        end
    end

    assign result_valid = valid_q2;
    assign result_data  = sum_q[`QUAD_PIXEL_W-1:0];

endmodule

`default_nettype wire

//--- hw/quad_prefetch_buffer.sv
`include "quad_config.svh"
`default_nettype none

module quad_prefetch_buffer
    import quad_data_pkg::*;
(
    input  logic      clk_core,
    input  logic      wr_en,
    input  col_t      wr_col,
    input  lane_vec_t pixel_data,
    input  col_t      rd_col,
    output lane_vec_t rd_data
);

    // One input row, one beat of 8 lanes per column
    lane_vec_t row_mem [`QUAD_MAX_COLS];

    always_ff @(posedge clk_core) begin
        if (wr_en) begin
            row_mem[wr_col] <= pixel_data;
        end
    end

    // Registered read, so data follows the column by one cycle
    always_ff @(posedge clk_core) begin
        rd_data <= row_mem[rd_col];
    end

endmodule

`default_nettype wire

//--- hw/quad_weight_table.sv
`include "quad_config.svh"
`default_nettype none

module quad_weight_table
    import quad_data_pkg::*;
(
    input  logic      clk_core,
    input  logic      rst,
    input  logic      weight_valid,
    input  logic      weight_ready,
    input  logic      job_complete_ack,
    input  lane_vec_t weight_data,
    input  kernel_t   rd_kernel,
    output lane_vec_t rd_weights
);

    lane_vec_t weight_mem [`QUAD_MAX_KERNELS];
    kernel_t   wr_idx;
    logic      wr_en;

    assign wr_en = weight_valid && weight_ready;

    // Kernels load in order, starting over after each job
    always_ff @(posedge clk_core) begin
        if (rst || job_complete_ack) begin
            wr_idx <= '0;
        end else if (wr_en) begin
            wr_idx <= wr_idx + kernel_t'(1);
        end
    end

    always_ff @(posedge clk_core) begin
        if (wr_en) begin
            weight_mem[wr_idx] <= weight_data;
        end
    end

    always_ff @(posedge clk_core) begin
        rd_weights <= weight_mem[rd_kernel];
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_cnn_quad -f build.f -o tb_cnn_quad \
    && { ./obj_dir/tb_cnn_quad > sim.log 2>&1 || true; } \
    && grep -qx "TESTS PASSED" sim.log \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed, see sim.log"; exit 1; }
